// File: hdl/pat_pkg.sv
package pat_pkg;

	// ======================================================================
	// isa widths and basic types
	// ======================================================================
	localparam int DATA_W = 8; // one data word, accumulator width
	localparam int INSTR_W = 20; // instruction word width

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [INSTR_W-1:0] instr_word_t;

	// i8 format: full 8 bit immediate below the opcode
	typedef struct packed {
		logic [4:0] rsvd; // old fieldp bits, ignored
		logic [1:0] cond;
		logic field_op; // reserved, decoded as zero
		logic [3:0] opcode;
		logic [7:0] imm8;
	} i8_fmt_t;

	// ext format: i3 and i0 share the prefixed encoding
	typedef struct packed {
		logic [4:0] rsvd;
		logic [1:0] cond;
		logic field_op;
		logic [3:0] prefix; // all ones for i3/i0
		logic [3:0] sub_op; // i3 opcode, or i0 prefix
		logic [3:0] low; // i0 opcode, i3 imm in [2:0]
	} ext_fmt_t;

	typedef union packed {
		i8_fmt_t i8;
		ext_fmt_t ext;
	} pat_instr_u;

	// ======================================================================
	// opcodes
	// ======================================================================
	typedef enum logic [3:0] {
		OP_OR = 4'd0, OP_AND = 4'd1, OP_ADDM = 4'd2, OP_SUBM = 4'd3,
		OP_ADD = 4'd4, OP_SUB = 4'd5, OP_LDI = 4'd6, OP_LDM = 4'd7,
		OP_BF = 4'd8, OP_STM = 4'd11, OP_I3_PREFIX = 4'd15
	} op_i8_e; // 9, 10, 12..14 are free slots -> nop

	typedef enum logic [3:0] {I3_SHL = 4'd0, I3_SHR = 4'd2, I3_OUT = 4'd8, I3_I0_PREFIX = 4'd15} op_i3_e;
	typedef enum logic [3:0] {I0_NOT = 4'd0, I0_TEST = 4'd2, I0_NOP = 4'd15} op_i0_e;
	typedef enum logic [1:0] {COND_Z = 2'd0, COND_NZ = 2'd1, COND_N = 2'd2, COND_ALWAYS = 2'd3} cond_e;

	typedef enum logic [2:0] {
		ALU_PASS_B, ALU_OR, ALU_AND, ALU_NOT, ALU_ADD, ALU_SUB, ALU_SHL, ALU_SHR
	} alu_op_e;

	localparam instr_word_t INSTR_NOP = 20'h06FFF; // i0 nop, cond always

endpackage

// File: hdl/pat_ifs.sv
`timescale 1ns/1ps

// decoded bundle, decoder -> execute, one per cycle
interface exec_ctrl_if import pat_pkg::*; #(
	parameter int pc_width = 10
) ();
	logic valid; // qualifies everything below
	alu_op_e alu_op;
	data_t operand_b; // memory word, imm8 or zero-extended imm3
	cond_e cond;
	logic [pc_width-1:0] instr_addr; // branch base
	logic write_acc;
	logic store;
	logic branch;
	logic out;
	logic test;

	modport decode(output valid, alu_op, operand_b, cond, instr_addr,
		write_acc, store, branch, out, test);
	modport execute(input valid, alu_op, operand_b, cond, instr_addr,
		write_acc, store, branch, out, test);
endinterface

// data memory, read from decode, write from execute
interface dmem_if import pat_pkg::*; ();
	data_t rd_addr;
	data_t rd_data; // combinational
	logic wr_en; // write lands on the edge where this is high
	data_t wr_addr;
	data_t wr_data;

	modport decode(output rd_addr, input rd_data);
	modport execute(output wr_en, wr_addr, wr_data);
	modport mem(input rd_addr, wr_en, wr_addr, wr_data, output rd_data);
endinterface

// File: hdl/pat_alu.sv
`timescale 1ns/1ps

module pat_alu import pat_pkg::*; (
	input data_t i_a, // accumulator
	input data_t i_b, // selected operand
	input alu_op_e i_op,
	output data_t o_y
);

	data_t add_sub; // shared adder, b inverted for subtract
	logic is_sub;

	assign is_sub = (i_op == ALU_SUB);
	assign add_sub = i_a + (is_sub ? ~i_b : i_b) + data_t'(is_sub);

	always_comb
	begin
		case (i_op)
			ALU_PASS_B: o_y = i_b; // ldi, ldm
			ALU_OR: o_y = i_a | i_b;
			ALU_AND: o_y = i_a & i_b;
			ALU_NOT: o_y = ~i_a;
			ALU_ADD,
			ALU_SUB: o_y = add_sub; // wraps mod 256
			ALU_SHL: o_y = i_a << i_b[2:0]; // logical, 0..7
			ALU_SHR: o_y = i_a >> i_b[2:0];
			default: o_y = i_b;
		endcase
	end

endmodule

// File: hdl/pat_fetch_unit.sv
`timescale 1ns/1ps

module pat_fetch_unit import pat_pkg::*; #(
	parameter int pc_width = 10
) (
	input logic clk,
	input logic reset,
	input instr_word_t i_instruction, // word for the pc of the previous cycle
	input logic i_jump,
	input logic [pc_width-1:0] i_jump_target,
	output logic [pc_width-1:0] o_pc,
	output pat_instr_u o_instr,
	output logic [pc_width-1:0] o_instr_addr,
	output logic o_instr_valid
);

	logic [pc_width-1:0] pc_q;
	logic [pc_width-1:0] pc_prev_q; // address of the word now on i_instruction
	logic arriving_valid_q; // word now on i_instruction belongs to the live stream
	instr_word_t ir_q;

	// ======================================================================
	// program counter and squash state
	// ======================================================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc_q <= '0;
			arriving_valid_q <= 1'b0;
			o_instr_valid <= 1'b0;
		end
		else
		begin
			pc_q <= i_jump ? i_jump_target : pc_q + 1'b1;
			// source samples the old pc on this edge, so its next word is stale too
			arriving_valid_q <= !i_jump;
			o_instr_valid <= arriving_valid_q && !i_jump; // drop word captured now
		end
	end

	// instruction register, tagged with its own address
	always_ff @(posedge clk)
	begin
		pc_prev_q <= pc_q;
		ir_q <= i_instruction;
		o_instr_addr <= pc_prev_q;
	end

	assign o_pc = pc_q;
	assign o_instr = o_instr_valid ? ir_q : INSTR_NOP; // dead slot shows a nop

endmodule

// File: hdl/pat_decoder.sv
`timescale 1ns/1ps

module pat_decoder import pat_pkg::*; #(
	parameter int pc_width = 10
) (
	input logic clk,
	input logic reset,
	input pat_instr_u i_instr,
	input logic [pc_width-1:0] i_instr_addr,
	input logic i_instr_valid,
	input logic i_jump, // squash whatever is decoded this cycle
	exec_ctrl_if.decode ctrl,
	dmem_if.decode dmem
);

	logic is_ext; // i8 opcode is the prefix
	logic is_i0; // ext word whose i3 opcode is the prefix
	alu_op_e dec_alu_op;
	logic dec_use_mem;
	logic dec_use_imm3;
	logic dec_write_acc;
	logic dec_store;
	logic dec_branch;
	logic dec_out;
	logic dec_test;
	data_t dec_operand;

	assign is_ext = (i_instr.i8.opcode == OP_I3_PREFIX);
	assign is_i0 = is_ext && (i_instr.ext.sub_op == I3_I0_PREFIX);

	// ======================================================================
	// opcode decode
	// ======================================================================
	always_comb
	begin
		dec_alu_op = ALU_PASS_B;
		dec_use_mem = 1'b0;
		dec_use_imm3 = 1'b0;
		dec_write_acc = 1'b0;
		dec_store = 1'b0;
		dec_branch = 1'b0;
		dec_out = 1'b0;
		dec_test = 1'b0;
		if (!is_ext)
		begin
			case (i_instr.i8.opcode)
				OP_OR: {dec_alu_op, dec_write_acc} = {ALU_OR, 1'b1};
				OP_AND: {dec_alu_op, dec_write_acc} = {ALU_AND, 1'b1};
				OP_ADDM: {dec_alu_op, dec_write_acc, dec_use_mem} = {ALU_ADD, 2'b11};
				OP_SUBM: {dec_alu_op, dec_write_acc, dec_use_mem} = {ALU_SUB, 2'b11};
				OP_ADD: {dec_alu_op, dec_write_acc} = {ALU_ADD, 1'b1};
				OP_SUB: {dec_alu_op, dec_write_acc} = {ALU_SUB, 1'b1};
				OP_LDI: dec_write_acc = 1'b1; // pass_b of imm8
				OP_LDM: {dec_write_acc, dec_use_mem} = 2'b11;
				OP_BF: dec_branch = 1'b1; // imm8 is the signed offset
				OP_STM: dec_store = 1'b1; // imm8 is the address
				default: dec_write_acc = 1'b0; // free slot, nop
			endcase
		end
		else if (!is_i0)
		begin
			case (i_instr.ext.sub_op)
				I3_SHL: {dec_alu_op, dec_write_acc, dec_use_imm3} = {ALU_SHL, 2'b11};
				I3_SHR: {dec_alu_op, dec_write_acc, dec_use_imm3} = {ALU_SHR, 2'b11};
				I3_OUT: dec_out = 1'b1;
				default: dec_out = 1'b0; // nop
			endcase
		end
		else
		begin
			case (i_instr.ext.low)
				I0_NOT: {dec_alu_op, dec_write_acc} = {ALU_NOT, 1'b1};
				I0_TEST: dec_test = 1'b1;
				default: dec_test = 1'b0; // I0_NOP and free slots
			endcase
		end
	end

	// operand b: memory, i3 imm or imm8
	assign dmem.rd_addr = i_instr.i8.imm8; // memory folds it to its depth
	assign dec_operand = dec_use_mem ? dmem.rd_data
		: dec_use_imm3 ? {5'b0, i_instr.ext.low[2:0]} : i_instr.i8.imm8;

	// ======================================================================
	// decode pipeline register
	// ======================================================================
	always_ff @(posedge clk)
	begin
		if (reset)
			ctrl.valid <= 1'b0;
		else
			ctrl.valid <= i_instr_valid && !i_jump;
	end

	always_ff @(posedge clk)
	begin
		ctrl.alu_op <= dec_alu_op;
		ctrl.operand_b <= dec_operand;
		ctrl.cond <= cond_e'(i_instr.i8.cond);
		ctrl.instr_addr <= i_instr_addr;
		ctrl.write_acc <= dec_write_acc;
		ctrl.store <= dec_store;
		ctrl.branch <= dec_branch;
		ctrl.out <= dec_out;
		ctrl.test <= dec_test;
	end

endmodule

// File: hdl/pat_execute.sv
`timescale 1ns/1ps

module pat_execute import pat_pkg::*; #(
	parameter int pc_width = 10
) (
	input logic clk,
	input logic reset,
	exec_ctrl_if.execute ctrl,
	dmem_if.execute dmem,
	output logic o_jump, // one cycle pulse
	output logic [pc_width-1:0] o_jump_target,
	output data_t o_outputs,
	output logic o_out_strobe
);

	data_t acc;
	logic z; // zero flag, set by test only
	logic n; // negative flag
	logic cond_ok;
	logic commit;
	data_t alu_y;
	logic signed [pc_width-1:0] branch_offset; // imm8 sign-extended

	pat_alu u_alu (
		.i_a (acc),
		.i_b (ctrl.operand_b),
		.i_op(ctrl.alu_op),
		.o_y (alu_y)
	);

	// ======================================================================
	// condition check
	// ======================================================================
	always_comb
	begin
		case (ctrl.cond)
			COND_Z: cond_ok = z;
			COND_NZ: cond_ok = !z;
			COND_N: cond_ok = n;
			default: cond_ok = 1'b1; // always
		endcase
	end

	// bundle behind a taken branch is dropped while jump is up
	assign commit = ctrl.valid && cond_ok && !o_jump;
	assign branch_offset = $signed(ctrl.operand_b);

	// stm goes out this cycle so the write lands on the commit edge
	assign dmem.wr_en = commit && ctrl.store;
	assign dmem.wr_addr = ctrl.operand_b;
	assign dmem.wr_data = acc;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			acc <= '0;
			z <= 1'b0;
			n <= 1'b0;
			o_outputs <= '0;
			o_out_strobe <= 1'b0;
			o_jump <= 1'b0;
		end
		else
		begin
			o_jump <= commit && ctrl.branch;
			o_out_strobe <= commit && ctrl.out;
			if (commit && ctrl.write_acc)
				acc <= alu_y;
			if (commit && ctrl.test)
			begin
				z <= (acc == '0);
				n <= acc[DATA_W-1];
			end
			if (commit && ctrl.out)
				o_outputs <= acc;
		end
	end

	// target relative to the bf itself, offset 0 spins in place
	always_ff @(posedge clk)
	begin
		if (commit && ctrl.branch)
			o_jump_target <= ctrl.instr_addr + pc_width'(branch_offset);
	end

endmodule

// File: hdl/pat_data_mem.sv
`timescale 1ns/1ps

module pat_data_mem import pat_pkg::*; #(
	parameter int dmem_depth = 8
) (
	input logic clk,
	dmem_if.mem mem
);

	localparam int addr_w = (dmem_depth > 1) ? $clog2(dmem_depth) : 1;

	data_t storage [dmem_depth];
	logic [addr_w-1:0] rd_idx;
	logic [addr_w-1:0] wr_idx;

	assign rd_idx = addr_w'(mem.rd_addr % dmem_depth); // address wraps at depth
	assign wr_idx = addr_w'(mem.wr_addr % dmem_depth);

	always_ff @(posedge clk)
	begin
		if (mem.wr_en)
			storage[wr_idx] <= mem.wr_data;
	end

	// bypass: a read of the word being written sees the new value
	assign mem.rd_data = (mem.wr_en && wr_idx == rd_idx) ? mem.wr_data : storage[rd_idx];

endmodule

// File: hdl/pat_top.sv
`timescale 1ns/1ps

module pat_top import pat_pkg::*; #(
	parameter int pc_width = 10, // 8 or more
	parameter int dmem_depth = 8 // up to 256
) (
	input logic clk,
	input logic reset,
	input instr_word_t i_instruction,
	output logic [pc_width-1:0] o_pc,
	output data_t o_outputs,
	output logic o_out_strobe
);

	pat_instr_u instr;
	logic [pc_width-1:0] instr_addr;
	logic instr_valid;
	logic jump;
	logic [pc_width-1:0] jump_target;

	exec_ctrl_if #(.pc_width(pc_width)) u_ctrl_if ();
	dmem_if u_dmem_if ();

	// ======================================================================
	// fetch -> decode -> execute
	// ======================================================================
	pat_fetch_unit #(.pc_width(pc_width)) u_fetch (
		.clk          (clk),
		.reset        (reset),
		.i_instruction(i_instruction),
		.i_jump       (jump),
		.i_jump_target(jump_target),
		.o_pc         (o_pc),
		.o_instr      (instr),
		.o_instr_addr (instr_addr),
		.o_instr_valid(instr_valid)
	);

	pat_decoder #(.pc_width(pc_width)) u_decoder (
		.clk          (clk),
		.reset        (reset),
		.i_instr      (instr),
		.i_instr_addr (instr_addr),
		.i_instr_valid(instr_valid),
		.i_jump       (jump),
		.ctrl         (u_ctrl_if.decode),
		.dmem         (u_dmem_if.decode)
	);

	pat_execute #(.pc_width(pc_width)) u_execute (
		.clk          (clk),
		.reset        (reset),
		.ctrl         (u_ctrl_if.execute),
		.dmem         (u_dmem_if.execute),
		.o_jump       (jump),
		.o_jump_target(jump_target),
		.o_outputs    (o_outputs),
		.o_out_strobe (o_out_strobe)
	);

	pat_data_mem #(.dmem_depth(dmem_depth)) u_dmem (
		.clk(clk),
		.mem(u_dmem_if.mem)
	);

endmodule

// File: testbench/pat_clock_gen.sv
`timescale 1ns/1ps

module pat_clock_gen #(
	parameter int half_period_ns = 10, // 20 ns clock
	parameter int reset_cycles = 3
) (
	input logic i_reset_req, // sampled at the edge, restarts the reset window
	output logic o_clk,
	output logic o_reset
);

	int reset_left = reset_cycles; // power-on reset

	initial
	begin
		o_clk = 1'b0;
		forever #(half_period_ns) o_clk = ~o_clk;
	end

	always @(posedge o_clk)
	begin
		if (i_reset_req)
			reset_left <= reset_cycles;
		else if (reset_left > 0)
			reset_left <= reset_left - 1;
	end

	assign o_reset = (reset_left > 0); // high across reset_cycles rising edges

endmodule

// File: testbench/pat_tb.sv
`timescale 1ns/1ps

module pat_tb import pat_pkg::*; ();

	localparam int PC_W = 10;
	localparam int NUM_ROWS = 6;
	localparam int MAX_WORDS = 16;
	localparam int MAX_OUTS = 4;
	localparam int STROBE_TIMEOUT = 200; // cycles allowed per expected strobe
	localparam int RESET_TIMEOUT = 10;
	localparam int QUIET_CYCLES = 20; // halt window after the last output
	localparam logic [31:0] SEED = 32'h49777898;

	logic clk;
	logic reset;
	logic reset_req = 1'b0;
	instr_word_t i_instruction = INSTR_NOP;
	logic [PC_W-1:0] o_pc;
	data_t o_outputs;
	logic o_out_strobe;

	// ======================================================================
	// stimulus table with one program and its expected bytes per row
	// ======================================================================
	instr_word_t row_prog [NUM_ROWS][MAX_WORDS];
	int row_len [NUM_ROWS];
	data_t row_exp [NUM_ROWS][MAX_OUTS];
	int row_cnt [NUM_ROWS];
	int cur_row = 0; // row served by the instruction source

	pat_clock_gen u_clk_gen (
		.i_reset_req(reset_req),
		.o_clk      (clk),
		.o_reset    (reset)
	);

	pat_top #(.pc_width(PC_W)) u_pat_top (
		.clk          (clk),
		.reset        (reset),
		.i_instruction(i_instruction),
		.o_pc         (o_pc),
		.o_outputs    (o_outputs),
		.o_out_strobe (o_out_strobe)
	);

	// word builders that follow the isa field layout
	function automatic instr_word_t enc_i8(logic [1:0] cond, logic [3:0] op, data_t imm);
		return {5'b0, cond, 1'b0, op, imm};
	endfunction

	function automatic instr_word_t enc_i3(logic [1:0] cond, logic [3:0] op, logic [2:0] imm);
		return {5'b0, cond, 1'b0, 4'hF, op, 1'b0, imm}; // i3 behind the prefix
	endfunction

	function automatic instr_word_t enc_i0(logic [1:0] cond, logic [3:0] op);
		return {5'b0, cond, 1'b0, 4'hF, 4'hF, op}; // two prefixes
	endfunction

	function automatic instr_word_t out_if(logic [1:0] cond);
		return enc_i3(cond, I3_OUT, 3'd0);
	endfunction

	function automatic instr_word_t halt_word();
		return enc_i8(COND_ALWAYS, OP_BF, 8'h00); // bf to itself
	endfunction

	// addresses past the program give a nop
	function automatic instr_word_t fetch_word(logic [PC_W-1:0] addr);
		if (addr < row_len[cur_row])
			return row_prog[cur_row][addr];
		return INSTR_NOP;
	endfunction

	always @(posedge clk)
	begin
		i_instruction <= fetch_word(o_pc); // valid the cycle after o_pc
	end

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic put_word(input int r, input instr_word_t w);
		assert (row_len[r] < MAX_WORDS)
		else fail_now("a program in the stimulus table is longer than 16 words");
		row_prog[r][row_len[r]] = w;
		row_len[r]++;
	endtask

	task automatic put_exp(input int r, input data_t v);
		row_exp[r][row_cnt[r]] = v;
		row_cnt[r]++;
	endtask

	task automatic build_table();
		data_t x, y, v, w, u, t, r0, neg, br;
		logic [2:0] s;
		x = 8'($urandom);
		y = 8'($urandom);
		s = 3'($urandom_range(7, 0));
		v = 8'($urandom);
		w = v ^ 8'h3C; // differs from v so a stale read shows
		u = w ^ 8'hA5;
		t = 8'($urandom);
		r0 = 8'($urandom);
		neg = 8'h80 | 8'($urandom); // top bit set
		br = 8'($urandom);
		foreach (row_len[i])
		begin
			row_len[i] = 0;
			row_cnt[i] = 0;
		end
		// row 0 checks ldi then out after reset
		put_word(0, enc_i8(COND_ALWAYS, OP_LDI, r0));
		put_word(0, out_if(COND_ALWAYS));
		put_word(0, halt_word());
		put_exp(0, r0);
		// row 1 covers add, sub, or and and with immediates
		put_word(1, enc_i8(COND_ALWAYS, OP_LDI, x));
		put_word(1, enc_i8(COND_ALWAYS, OP_ADD, y));
		put_word(1, out_if(COND_ALWAYS));
		put_word(1, enc_i8(COND_ALWAYS, OP_LDI, x));
		put_word(1, enc_i8(COND_ALWAYS, OP_SUB, y));
		put_word(1, out_if(COND_ALWAYS));
		put_word(1, enc_i8(COND_ALWAYS, OP_LDI, x));
		put_word(1, enc_i8(COND_ALWAYS, OP_OR, y));
		put_word(1, out_if(COND_ALWAYS));
		put_word(1, enc_i8(COND_ALWAYS, OP_LDI, x));
		put_word(1, enc_i8(COND_ALWAYS, OP_AND, y));
		put_word(1, out_if(COND_ALWAYS));
		put_word(1, halt_word());
		put_exp(1, data_t'(x + y)); // mod 256
		put_exp(1, data_t'(x - y));
		put_exp(1, x | y);
		put_exp(1, x & y);
		// row 2 covers not and the two shifts
		put_word(2, enc_i8(COND_ALWAYS, OP_LDI, x));
		put_word(2, enc_i0(COND_ALWAYS, I0_NOT));
		put_word(2, out_if(COND_ALWAYS));
		put_word(2, enc_i8(COND_ALWAYS, OP_LDI, x));
		put_word(2, enc_i3(COND_ALWAYS, I3_SHL, s));
		put_word(2, out_if(COND_ALWAYS));
		put_word(2, enc_i8(COND_ALWAYS, OP_LDI, x));
		put_word(2, enc_i3(COND_ALWAYS, I3_SHR, s));
		put_word(2, out_if(COND_ALWAYS));
		put_word(2, halt_word());
		put_exp(2, ~x);
		put_exp(2, data_t'(x << s));
		put_exp(2, x >> s);
		// row 3 has stm followed at once by ldm, addm and subm of the same address
		put_word(3, enc_i8(COND_ALWAYS, OP_LDI, v));
		put_word(3, enc_i8(COND_ALWAYS, OP_STM, 8'h05));
		put_word(3, enc_i8(COND_ALWAYS, OP_LDM, 8'h05)); // bypassed read
		put_word(3, out_if(COND_ALWAYS));
		put_word(3, enc_i8(COND_ALWAYS, OP_LDI, w));
		put_word(3, enc_i8(COND_ALWAYS, OP_STM, 8'h05));
		put_word(3, enc_i8(COND_ALWAYS, OP_ADDM, 8'h05)); // w + w
		put_word(3, out_if(COND_ALWAYS));
		put_word(3, enc_i8(COND_ALWAYS, OP_LDI, u));
		put_word(3, enc_i8(COND_ALWAYS, OP_STM, 8'h05));
		put_word(3, enc_i8(COND_ALWAYS, OP_SUBM, 8'h05)); // u - u
		put_word(3, out_if(COND_ALWAYS));
		put_word(3, enc_i8(COND_ALWAYS, OP_LDI, t));
		put_word(3, enc_i8(COND_ALWAYS, OP_SUBM, 8'h05)); // memory still holds u
		put_word(3, out_if(COND_ALWAYS));
		put_word(3, halt_word());
		put_exp(3, v);
		put_exp(3, data_t'(w + w));
		put_exp(3, 8'h00);
		put_exp(3, data_t'(t - u));
		// row 4 checks condition codes after test
		put_word(4, enc_i8(COND_ALWAYS, OP_LDI, 8'h00));
		put_word(4, enc_i0(COND_ALWAYS, I0_TEST)); // z=1 n=0
		put_word(4, enc_i8(COND_ALWAYS, OP_LDI, 8'h11)); // flags untouched by ldi
		put_word(4, out_if(COND_Z));
		put_word(4, enc_i8(COND_ALWAYS, OP_LDI, 8'h33)); // shows if the NZ out runs
		put_word(4, out_if(COND_NZ)); // skipped
		put_word(4, enc_i8(COND_ALWAYS, OP_LDI, neg));
		put_word(4, enc_i0(COND_ALWAYS, I0_TEST)); // z=0 n=1
		put_word(4, out_if(COND_N));
		put_word(4, out_if(COND_Z)); // skipped
		put_word(4, enc_i8(COND_ALWAYS, OP_LDI, 8'h22));
		put_word(4, out_if(COND_NZ));
		put_word(4, halt_word());
		put_exp(4, 8'h11);
		put_exp(4, neg);
		put_exp(4, 8'h22);
		// row 5 takes a forward branch over two outs and then runs a countdown loop
		put_word(5, enc_i8(COND_ALWAYS, OP_LDI, br));
		put_word(5, enc_i8(COND_ALWAYS, OP_BF, 8'h03)); // to word 4
		put_word(5, out_if(COND_ALWAYS));
		put_word(5, out_if(COND_ALWAYS));
		put_word(5, out_if(COND_ALWAYS));
		put_word(5, enc_i8(COND_ALWAYS, OP_LDI, 8'h03));
		put_word(5, out_if(COND_ALWAYS)); // loop head at word 6
		put_word(5, enc_i8(COND_ALWAYS, OP_SUB, 8'h01));
		put_word(5, enc_i0(COND_ALWAYS, I0_TEST));
		put_word(5, enc_i8(COND_NZ, OP_BF, 8'hFD)); // -3 jumps back to word 6
		put_word(5, halt_word());
		put_exp(5, br);
		put_exp(5, 8'h03);
		put_exp(5, 8'h02);
		put_exp(5, 8'h01);
	endtask

	// ======================================================================
	// waits and checks
	// ======================================================================
	task automatic wait_reset_level(input logic level);
		int n;
		n = 0;
		while (reset !== level)
		begin
			@(posedge clk);
			n++;
			assert (n <= RESET_TIMEOUT)
			else fail_now("reset did not reach the requested level in time");
		end
	endtask

	task automatic wait_strobe(output data_t value);
		int n;
		n = 0;
		@(posedge clk); // never reuse the strobe seen last time
		while (o_out_strobe !== 1'b1)
		begin
			n++;
			assert (n <= STROBE_TIMEOUT)
			else fail_now("timed out waiting for o_out_strobe");
			@(posedge clk);
		end
		value = o_outputs; // pre-edge value set together with the strobe
	endtask

	task automatic check_quiet();
		for (int i = 0; i < QUIET_CYCLES; i++)
		begin
			@(posedge clk);
			assert (o_out_strobe !== 1'b1)
			else fail_now("o_out_strobe pulsed after the last expected output");
		end
	endtask

	task automatic run_row(input int r);
		data_t got;
		@(posedge clk);
		cur_row <= r;
		reset_req <= 1'b1;
		@(posedge clk);
		reset_req <= 1'b0;
		wait_reset_level(1'b1);
		wait_reset_level(1'b0); // first edge out of reset
		assert (o_pc === '0)
		else fail_now($sformatf("ERR t=%0t o_pc exp=000 got=%03h", $time, o_pc));
		assert (o_outputs === 8'h00)
		else fail_now($sformatf("ERR t=%0t o_outputs exp=00 got=%02h", $time, o_outputs));
		assert (o_out_strobe === 1'b0)
		else fail_now($sformatf("ERR t=%0t o_out_strobe exp=0 got=%0b", $time, o_out_strobe));
		for (int k = 0; k < row_cnt[r]; k++)
		begin
			wait_strobe(got);
			assert (got === row_exp[r][k])
			else fail_now($sformatf("ERR t=%0t o_outputs exp=%02h got=%02h",
				$time, row_exp[r][k], got));
		end
		check_quiet(); // halt loop must stay silent
	endtask

	initial
	begin
		void'($urandom(SEED));
		build_table();
		for (int r = 0; r < NUM_ROWS; r++)
			run_row(r);
		$display("Result: PASSED");
		$finish;
	end

endmodule

// File: project.f
hdl/pat_pkg.sv
hdl/pat_ifs.sv
hdl/pat_alu.sv
hdl/pat_fetch_unit.sv
hdl/pat_decoder.sv
hdl/pat_execute.sv
hdl/pat_data_mem.sv
hdl/pat_top.sv
testbench/pat_clock_gen.sv
testbench/pat_tb.sv

// File: Makefile
VERILATOR = verilator
TOP = pat_tb
FILELIST = project.f
BUILD_DIR = obj_dir
VFLAGS = --binary --timing --assert -Wno-fatal -j 0 --Mdir $(BUILD_DIR)
LINT_FLAGS = --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
